//--- hdl/cpu_cfg_pkg.sv
`default_nettype none

package cpu_cfg_pkg;

	// instructions returned per cache line
	localparam int FETCH_NUM = 2;
	localparam int FETCH_WIDTH = $clog2(FETCH_NUM);

	// low address bits dropped for a line request
	localparam int ALIGN_BITS = 3;

	// default reset address
	localparam logic [31:0] BOOT_VEC = 32'hBFC0_0000;

endpackage

`default_nettype wire

//--- hdl/fetch_types_pkg.sv
`default_nettype none

package fetch_types_pkg;

	// virtual address as seen by fetch
	typedef logic [31:0] virt_t;

	// raw instruction word
	typedef logic [31:0] instr_t;

	// one cache line, slot 0 in the low word
	typedef logic [cpu_cfg_pkg::FETCH_NUM*32-1:0] line_t;

	// per-slot prediction
	typedef struct packed {
		logic  taken;
		virt_t target;
	} predict_t;

	// queue entry handed to decode
	typedef struct packed {
		virt_t    vaddr;
		instr_t   instr;
		predict_t pred;
	} fetch_entry_t;

endpackage

`default_nettype wire

//--- hdl/branch_res_if.sv
`default_nettype none

// resolved branch coming back from execute
interface branch_res_if;

	logic                   valid;
	logic                   mispredict;
	logic                   taken;
	fetch_types_pkg::virt_t pc;
	fetch_types_pkg::virt_t target;

	modport src (
		output valid,
		output mispredict,
		output taken,
		output pc,
		output target
	);

	modport sink (
		input valid,
		input mispredict,
		input taken,
		input pc,
		input target
	);

endinterface

`default_nettype wire

//--- hdl/pc_generator.sv
`default_nettype none

module pc_generator #(
	parameter fetch_types_pkg::virt_t RESET_BASE = cpu_cfg_pkg::BOOT_VEC
)(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hold,
	input  logic                   except_valid,
	input  fetch_types_pkg::virt_t except_vec,
	input  logic                   predict_valid,
	input  fetch_types_pkg::virt_t predict_vaddr,
	branch_res_if.sink             res,
	output fetch_types_pkg::virt_t pc
);

	localparam int AB = cpu_cfg_pkg::ALIGN_BITS;

	fetch_types_pkg::virt_t seq_pc;
	fetch_types_pkg::virt_t pc_next;
	logic                   mispredict;

	// next line after the current one
	assign seq_pc = {pc[31:AB] + 1'b1, {AB{1'b0}}};
	assign mispredict = res.valid & res.mispredict;

	// redirects win over hold
	always_comb begin
		if (except_valid) begin
			pc_next = except_vec;
		end else if (mispredict) begin
			pc_next = res.taken ? res.target : res.pc + 32'd4;
		end else if (hold) begin
			pc_next = pc;
		end else if (predict_valid) begin
			pc_next = predict_vaddr;
		end else begin
			pc_next = seq_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_BASE;
		end else begin
			pc <= pc_next;
		end
	end

	// every target source is expected to be word aligned
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
`default_nettype none

module branch_predictor #(
	parameter int BTB_SIZE = 16
)(
	input  logic                                                clk,
	input  logic                                                rst,
	input  fetch_types_pkg::virt_t                              line_pc,
	input  logic [cpu_cfg_pkg::FETCH_NUM-1:0]                   slot_valid,
	branch_res_if.sink                                          res,
	output logic                                                predict_valid,
	output fetch_types_pkg::virt_t                              predict_vaddr,
	output fetch_types_pkg::predict_t [cpu_cfg_pkg::FETCH_NUM-1:0] pred
);

	localparam int FN = cpu_cfg_pkg::FETCH_NUM;
	localparam int IDX_W = $clog2(BTB_SIZE);
	localparam int TAG_W = 30 - IDX_W;

	logic [BTB_SIZE-1:0]    btb_valid;
	logic [TAG_W-1:0]       btb_tag [BTB_SIZE];
	fetch_types_pkg::virt_t btb_target [BTB_SIZE];
	logic [1:0]             btb_cnt [BTB_SIZE];

	logic [IDX_W-1:0] res_idx;
	logic [TAG_W-1:0] res_tag;
	logic             res_hit;
	logic [FN-1:0]    slot_taken;

	// indexed by word address
	assign res_idx = res.pc[IDX_W+1:2];
	assign res_tag = res.pc[31:IDX_W+2];
	assign res_hit = btb_valid[res_idx] && (btb_tag[res_idx] == res_tag);

	// walk slots from the top so the lowest taken slot wins
	always_comb begin
		fetch_types_pkg::virt_t slot_pc;
		logic [IDX_W-1:0]       idx;
		slot_pc = '0;
		idx = '0;
		predict_valid = 1'b0;
		predict_vaddr = '0;
		for (int i = FN - 1; i >= 0; i--) begin
			slot_pc = line_pc + 32'(4 * i);
			idx = slot_pc[IDX_W+1:2];
			slot_taken[i] = slot_valid[i] && btb_valid[idx] &&
				(btb_tag[idx] == slot_pc[31:IDX_W+2]) && btb_cnt[idx][1];
			pred[i].taken = slot_taken[i];
			pred[i].target = btb_target[idx];
			if (slot_taken[i]) begin
				predict_valid = 1'b1;
				predict_vaddr = btb_target[idx];
			end
		end
	end

	// allocate only on a taken miss
	always_ff @(posedge clk) begin
		if (rst) begin
			btb_valid <= '0;
		end else if (res.valid && res.taken && !res_hit) begin
			btb_valid[res_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (res.valid) begin
			if (res_hit) begin
				if (res.taken) begin
					btb_target[res_idx] <= res.target;
					if (btb_cnt[res_idx] != 2'd3) begin
						btb_cnt[res_idx] <= btb_cnt[res_idx] + 2'd1;
					end
				end else if (btb_cnt[res_idx] != 2'd0) begin
					btb_cnt[res_idx] <= btb_cnt[res_idx] - 2'd1;
				end
			end else if (res.taken) begin
				btb_tag[res_idx]    <= res_tag;
				btb_target[res_idx] <= res.target;
				btb_cnt[res_idx]    <= 2'd2; // weakly taken
			end
		end
	end

	// a taken resolve leaves its entry holding the resolved target
	a_taken_trains: assert property (@(posedge clk) disable iff (rst)
		res.valid && res.taken |=> btb_valid[$past(res_idx)] &&
			(btb_tag[$past(res_idx)] == $past(res_tag)) &&
			(btb_target[$past(res_idx)] == $past(res.target)));

endmodule

`default_nettype wire

//--- hdl/instr_queue.sv
`default_nettype none

module instr_queue #(
	parameter int QUEUE_DEPTH = 8
)(
	input  logic                                                     clk,
	input  logic                                                     rst,
	input  logic                                                     flush,
	input  logic [cpu_cfg_pkg::FETCH_WIDTH:0]                        push_num,
	input  fetch_types_pkg::fetch_entry_t [cpu_cfg_pkg::FETCH_NUM-1:0] push_entry,
	output logic                                                     almost_full,
	input  logic                                                     pop,
	output logic                                                     head_valid,
	output fetch_types_pkg::fetch_entry_t                            head
);

	localparam int FN = cpu_cfg_pkg::FETCH_NUM;
	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	fetch_types_pkg::fetch_entry_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic [PTR_W:0]   free_cnt;
	logic             do_pop;

	assign head_valid = (count != '0);
	assign head = mem[rd_ptr];
	assign do_pop = pop & head_valid;

	// room for a full line is required before a push
	assign free_cnt = (PTR_W + 1)'(QUEUE_DEPTH) - count;
	assign almost_full = free_cnt < (PTR_W + 1)'(FN);

	// written in slot order and wrapping at the end
	always_ff @(posedge clk) begin
		for (int i = 0; i < FN; i++) begin
			if (!flush && (i < push_num)) begin
				mem[wr_ptr + PTR_W'(i)] <= push_entry[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_W'(push_num);
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PTR_W + 1)'(push_num) - (PTR_W + 1)'(do_pop);
		end
	end

	// fetch must check almost_full before pushing
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!flush |-> (push_num <= free_cnt));

endmodule

`default_nettype wire

//--- hdl/instr_fetch.sv
`default_nettype none

module instr_fetch #(
	parameter fetch_types_pkg::virt_t RESET_BASE = cpu_cfg_pkg::BOOT_VEC,
	parameter int BTB_SIZE = 16,
	parameter int QUEUE_DEPTH = 8
)(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          except_valid,
	input  fetch_types_pkg::virt_t        except_vec,
	branch_res_if.sink                    res,
	output fetch_types_pkg::virt_t        icache_addr,
	output logic                          icache_flush,
	input  fetch_types_pkg::line_t        icache_data,
	input  logic                          icache_stall,
	input  logic                          fetch_ack,
	output logic                          head_valid,
	output fetch_types_pkg::fetch_entry_t head
);

	localparam int FN = cpu_cfg_pkg::FETCH_NUM;
	localparam int FW = cpu_cfg_pkg::FETCH_WIDTH;
	localparam int AB = cpu_cfg_pkg::ALIGN_BITS;

	logic                   hold;
	logic                   redirect;
	logic                   almost_full;
	fetch_types_pkg::virt_t pc;
	fetch_types_pkg::virt_t fetch_vaddr;
	fetch_types_pkg::virt_t line_pc;

	logic                   s2_valid;
	fetch_types_pkg::virt_t s2_vaddr;
	logic [FW-1:0]          offset;

	logic                   predict_valid;
	fetch_types_pkg::virt_t predict_vaddr;
	fetch_types_pkg::predict_t [FN-1:0] pred;

	logic [FN-1:0]          slot_valid;
	logic [FN-1:0]          push_mask;
	logic [FW:0]            push_num;
	fetch_types_pkg::fetch_entry_t [FN-1:0] slot_entry;
	fetch_types_pkg::fetch_entry_t [FN-1:0] push_entry;

	assign redirect = except_valid | (res.valid & res.mispredict);
	assign hold = icache_stall | almost_full;
	assign icache_flush = redirect;

	// stage 1 replays the stage-2 line while held
	assign fetch_vaddr = hold ? s2_vaddr : pc;
	assign icache_addr = {fetch_vaddr[31:AB], {AB{1'b0}}};

	pc_generator #(
		.RESET_BASE ( RESET_BASE )
	) pc_gen_i (
		.clk,
		.rst,
		.hold,
		.except_valid,
		.except_vec,
		.predict_valid,
		.predict_vaddr,
		.res,
		.pc
	);

	// line after a taken prediction is dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			s2_valid <= 1'b0;
			s2_vaddr <= RESET_BASE;
		end else if (redirect) begin
			s2_valid <= 1'b0;
		end else if (!hold) begin
			s2_valid <= !predict_valid;
			s2_vaddr <= pc;
		end
	end

	// stage 2
	assign offset = s2_vaddr[AB-1:2];
	assign line_pc = {s2_vaddr[31:AB], {AB{1'b0}}};

	always_comb begin
		for (int i = 0; i < FN; i++) begin
			slot_valid[i] = s2_valid && (i >= offset);
			slot_entry[i].vaddr = line_pc + 32'(4 * i);
			slot_entry[i].instr = icache_data[i*32 +: 32];
			slot_entry[i].pred = pred[i];
		end
	end

	branch_predictor #(
		.BTB_SIZE ( BTB_SIZE )
	) bp_i (
		.clk,
		.rst,
		.line_pc,
		.slot_valid,
		.res,
		.predict_valid,
		.predict_vaddr,
		.pred
	);

	// stop after the first taken slot, then pack from the offset
	always_comb begin
		logic taken_seen;
		taken_seen = 1'b0;
		push_num = '0;
		push_entry = slot_entry;
		for (int i = 0; i < FN; i++) begin
			push_mask[i] = slot_valid[i] & ~taken_seen;
			taken_seen = taken_seen | (push_mask[i] & pred[i].taken);
			if (push_mask[i]) begin
				push_num = push_num + 1'b1;
			end
		end
		for (int j = 0; j < FN; j++) begin
			if (j + offset < FN) begin
				push_entry[j] = slot_entry[j + offset];
			end
		end
		if (hold || redirect) begin
			push_num = '0;
		end
	end

	instr_queue #(
		.QUEUE_DEPTH ( QUEUE_DEPTH )
	) queue_i (
		.clk,
		.rst,
		.flush       ( redirect  ),
		.push_num,
		.push_entry,
		.almost_full,
		.pop         ( fetch_ack ),
		.head_valid,
		.head
	);

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`default_nettype none

module fetch_top #(
	parameter fetch_types_pkg::virt_t RESET_BASE = cpu_cfg_pkg::BOOT_VEC,
	parameter int BTB_SIZE = 16,
	parameter int QUEUE_DEPTH = 8
)(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   except_valid,
	input  fetch_types_pkg::virt_t except_vec,
	input  logic                   res_valid,
	input  logic                   res_mispredict,
	input  logic                   res_taken,
	input  fetch_types_pkg::virt_t res_pc,
	input  fetch_types_pkg::virt_t res_target,
	output fetch_types_pkg::virt_t icache_addr,
	output logic                   icache_flush,
	input  fetch_types_pkg::line_t icache_data,
	input  logic                   icache_stall,
	input  logic                   fetch_ack,
	output logic                   entry_valid,
	output fetch_types_pkg::virt_t entry_vaddr,
	output fetch_types_pkg::instr_t entry_instr,
	output logic                   entry_pred_taken,
	output fetch_types_pkg::virt_t entry_pred_target
);

	fetch_types_pkg::fetch_entry_t head;

	branch_res_if res_bus ();

	// source side of the resolve bus
	assign res_bus.valid      = res_valid;
	assign res_bus.mispredict = res_mispredict;
	assign res_bus.taken      = res_taken;
	assign res_bus.pc         = res_pc;
	assign res_bus.target     = res_target;

	instr_fetch #(
		.RESET_BASE  ( RESET_BASE  ),
		.BTB_SIZE    ( BTB_SIZE    ),
		.QUEUE_DEPTH ( QUEUE_DEPTH )
	) fetch_i (
		.clk,
		.rst,
		.except_valid,
		.except_vec,
		.res        ( res_bus.sink ),
		.icache_addr,
		.icache_flush,
		.icache_data,
		.icache_stall,
		.fetch_ack,
		.head_valid ( entry_valid  ),
		.head
	);

	assign entry_vaddr       = head.vaddr;
	assign entry_instr       = head.instr;
	assign entry_pred_taken  = head.pred.taken;
	assign entry_pred_target = head.pred.target;

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`default_nettype none

module fetch_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam fetch_types_pkg::virt_t EXC_VEC_DEFAULT = 32'hBFC0_0380;
	// branch trained in test 4 sits in slot 1 of its line
	localparam fetch_types_pkg::virt_t BR_PC = 32'h0000_8004;
	localparam fetch_types_pkg::virt_t BR_TARGET = 32'h0000_9000;
	localparam fetch_types_pkg::virt_t MIS_PC = 32'h0000_2010;
	localparam fetch_types_pkg::virt_t MIS_TARGET = 32'h0000_4000;
	// resolve that loses against the exception
	localparam fetch_types_pkg::virt_t LOST_PC = 32'h0000_3008;
	localparam fetch_types_pkg::virt_t LOST_TARGET = 32'h0000_5000;

	logic                    clk;
	logic                    rst;
	logic                    except_valid;
	fetch_types_pkg::virt_t  except_vec;
	logic                    res_valid;
	logic                    res_mispredict;
	logic                    res_taken;
	fetch_types_pkg::virt_t  res_pc;
	fetch_types_pkg::virt_t  res_target;
	fetch_types_pkg::virt_t  icache_addr;
	logic                    icache_flush;
	fetch_types_pkg::line_t  icache_data;
	logic                    icache_stall;
	logic                    fetch_ack;
	logic                    entry_valid;
	fetch_types_pkg::virt_t  entry_vaddr;
	fetch_types_pkg::instr_t entry_instr;
	logic                    entry_pred_taken;
	fetch_types_pkg::virt_t  entry_pred_target;

	fetch_types_pkg::virt_t line_addr;
	fetch_types_pkg::virt_t expected;
	fetch_types_pkg::virt_t watch_addr = '0;
	fetch_types_pkg::virt_t watch_target = '0;
	logic                   watch_taken = 1'b0;
	int                     watch_pop = 0;
	int                     pop_count = 0;
	int                     cmp_errors = 0;
	int                     tst_errors = 0;
	int                     err_mark = 0;
	int                     passed = 0;
	int                     failed = 0;
	bit                     ack_random = 1'b0;
	bit                     timed_out = 1'b0;

	fetch_top dut_i (
		.clk, .rst, .except_valid, .except_vec,
		.res_valid, .res_mispredict, .res_taken, .res_pc, .res_target,
		.icache_addr, .icache_flush, .icache_data, .icache_stall, .fetch_ack,
		.entry_valid, .entry_vaddr, .entry_instr, .entry_pred_taken, .entry_pred_target
	);

	// every word depends on all address bits
	function automatic fetch_types_pkg::instr_t mem_word(input fetch_types_pkg::virt_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
	endfunction

	// address of the entry that follows prev when nothing redirects
	function automatic fetch_types_pkg::virt_t next_vaddr(
		input fetch_types_pkg::virt_t prev_vaddr,
		input logic                   prev_taken,
		input fetch_types_pkg::virt_t prev_target
	);
		if (prev_taken) begin
			return prev_target;
		end else begin
			return prev_vaddr + 32'd4;
		end
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// cache model with one cycle of latency
	assign icache_data = {mem_word(line_addr + 32'd4), mem_word(line_addr)};

	initial begin
		line_addr = '0;
		forever begin
			@(posedge clk);
			if (!icache_stall) begin
				line_addr <= icache_addr;
			end
		end
	end

	// about one stall in five cycles, acks with gaps while ack_random is set
	initial begin
		void'($urandom(14));
		icache_stall = 1'b0;
		fetch_ack = 1'b0;
		forever begin
			@(posedge clk);
			icache_stall <= ($urandom % 5) == 0;
			if (ack_random) begin
				fetch_ack <= ($urandom % 4) == 0;
			end else begin
				fetch_ack <= 1'b1;
			end
		end
	end

	// checks every popped entry against the reference stream
	always @(posedge clk) begin : compare
		int   errs;
		logic flush_exp;
		errs = 0;
		flush_exp = except_valid || (res_valid && res_mispredict);
		assert (icache_flush == flush_exp) else begin
			$display("** Error @ %0t: icache_flush %b, expected %b",
				$time, icache_flush, flush_exp);
			errs++;
		end
		if (rst) begin
			expected = cpu_cfg_pkg::BOOT_VEC;
		end else begin
			if (entry_valid && fetch_ack) begin
				assert (entry_vaddr == expected) else begin
					$display("** Error @ %0t: entry vaddr %h, expected %h",
						$time, entry_vaddr, expected);
					errs++;
				end
				assert (entry_instr == mem_word(entry_vaddr)) else begin
					$display("** Error @ %0t: instr %h at %h, expected %h",
						$time, entry_instr, entry_vaddr, mem_word(entry_vaddr));
					errs++;
				end
				if (entry_vaddr == watch_addr) begin
					watch_pop <= pop_count + 1;
					watch_taken <= entry_pred_taken;
					watch_target <= entry_pred_target;
				end
				pop_count <= pop_count + 1;
				expected = next_vaddr(entry_vaddr, entry_pred_taken, entry_pred_target);
			end
			// exception first, then mispredict
			if (except_valid) begin
				expected = except_vec;
			end else if (res_valid && res_mispredict) begin
				expected = res_taken ? res_target : res_pc + 32'd4;
			end
		end
		cmp_errors <= cmp_errors + errs;
	end

	task automatic wait_pops(input int num, input int limit);
		int target;
		int cycles;
		target = pop_count + num;
		cycles = 0;
		while (pop_count < target && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (pop_count < target) begin
			$display("timeout: %0d entries still missing after %0d cycles",
				target - pop_count, limit);
			timed_out = 1'b1;
		end
	endtask

	// one-cycle strobe on the redirect and resolve inputs
	task automatic drive_redirect(
		input logic                   exc,
		input fetch_types_pkg::virt_t vec,
		input logic                   rv,
		input logic                   mis,
		input logic                   taken,
		input fetch_types_pkg::virt_t pc,
		input fetch_types_pkg::virt_t target
	);
		@(posedge clk);
		except_valid <= exc;
		except_vec <= vec;
		res_valid <= rv;
		res_mispredict <= mis;
		res_taken <= taken;
		res_pc <= pc;
		res_target <= target;
		@(posedge clk);
		except_valid <= 1'b0;
		res_valid <= 1'b0;
	endtask

	task automatic start_test();
		err_mark = cmp_errors + tst_errors;
	endtask

	task automatic end_test(input int num, input string name);
		int errs;
		@(posedge clk);
		errs = cmp_errors + tst_errors - err_mark;
		if (timed_out) begin
			$display("test %0d %s: timed out", num, name);
			failed++;
		end else if (errs == 0) begin
			$display("test %0d %s: pass", num, name);
			passed++;
		end else begin
			$display("test %0d %s: fail, %0d errors", num, name, errs);
			failed++;
		end
	endtask

	task automatic check_watch(input logic taken, input fetch_types_pkg::virt_t target,
		input int mark);
		assert (watch_pop > mark && watch_taken == taken && (!taken || watch_target == target))
		else begin
			$display("** Error @ %0t: entry %h seen %0d, taken %b to %h, expected taken %b",
				$time, watch_addr, watch_pop > mark, watch_taken, watch_target, taken);
			tst_errors++;
		end
	endtask

	initial begin
		int mark;
		rst = 1'b1;
		except_valid = 1'b0;
		except_vec = '0;
		res_valid = 1'b0;
		res_mispredict = 1'b0;
		res_taken = 1'b0;
		res_pc = '0;
		res_target = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		start_test();
		wait_pops(40, 400);
		end_test(1, "boot and sequential fetch");

		if (!timed_out) begin
			start_test();
			ack_random <= 1'b1;
			wait_pops(60, 1500);
			ack_random <= 1'b0;
			end_test(2, "back-pressure");
		end

		if (!timed_out) begin
			start_test();
			watch_addr <= MIS_TARGET;
			mark = pop_count;
			drive_redirect(1'b0, '0, 1'b1, 1'b1, 1'b1, MIS_PC, MIS_TARGET);
			wait_pops(8, 200);
			check_watch(1'b0, '0, mark);
			end_test(3, "mispredict redirect");
		end

		if (!timed_out) begin
			start_test();
			// trains the BTB and leaves fetch at the target
			drive_redirect(1'b0, '0, 1'b1, 1'b1, 1'b1, BR_PC, BR_TARGET);
			wait_pops(6, 200);
			watch_addr <= BR_PC;
			mark = pop_count;
			drive_redirect(1'b1, BR_PC - 32'd8, 1'b0, 1'b0, 1'b0, '0, '0);
			wait_pops(8, 200);
			check_watch(1'b1, BR_TARGET, mark);
			end_test(4, "trained prediction");
		end

		if (!timed_out) begin
			start_test();
			drive_redirect(1'b0, '0, 1'b1, 1'b0, 1'b0, BR_PC, '0);
			drive_redirect(1'b0, '0, 1'b1, 1'b0, 1'b0, BR_PC, '0);
			mark = pop_count;
			drive_redirect(1'b1, BR_PC - 32'd8, 1'b0, 1'b0, 1'b0, '0, '0);
			wait_pops(8, 200);
			check_watch(1'b0, '0, mark);
			end_test(5, "not-taken untraining");
		end

		if (!timed_out) begin
			start_test();
			watch_addr <= EXC_VEC_DEFAULT;
			mark = pop_count;
			drive_redirect(1'b1, EXC_VEC_DEFAULT, 1'b1, 1'b1, 1'b1, LOST_PC, LOST_TARGET);
			wait_pops(8, 200);
			check_watch(1'b0, '0, mark);
			end_test(6, "exception over mispredict");
		end

		// lets the error count of the last clock edge settle
		@(negedge clk);
		$display("tests passed %0d, failed %0d, entries %0d, errors %0d",
			passed, failed, pop_count, cmp_errors + tst_errors);
		if (failed == 0 && cmp_errors + tst_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/cpu_cfg_pkg.sv
hdl/fetch_types_pkg.sv
hdl/branch_res_if.sv
hdl/pc_generator.sv
hdl/branch_predictor.sv
hdl/instr_queue.sv
hdl/instr_fetch.sv
hdl/fetch_top.sv
verif/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module fetch_tb -f vlog.f -o fetch_sim \
	&& ./obj_dir/fetch_sim | tee sim.log \
	|| { echo "build or run error"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
